// ==== Bender.yml ====
package:
  name: hdc_bundler

sources:
  - include_dirs:
      - hw
    files:
      - hw/hdc_vec_pkg.sv
      - hw/hdc_stream_pkg.sv
      - hw/dim_counter.sv
      - hw/bundle_array.sv
      - hw/stream_packer.sv
      - hw/hdc_bundler_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/hdc_bundler_checker.sv
      - verif/hdc_bundler_tb.sv

// ==== files.f ====
+incdir+hw
hw/hdc_vec_pkg.sv
hw/hdc_stream_pkg.sv
hw/dim_counter.sv
hw/bundle_array.sv
hw/stream_packer.sv
hw/hdc_bundler_top.sv
verif/hdc_bundler_checker.sv
verif/hdc_bundler_tb.sv

// ==== hw/bundle_array.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hdc_macros.svh"

module bundle_array (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   clear,
    input  hdc_vec_pkg::core_mask_t                store,
    input  hdc_vec_pkg::hv_t [`HDC_CORE_NUM-1:0]   core_vec,
    output hdc_vec_pkg::hv_t                       sign_vec
);

    import hdc_vec_pkg::*;

    // one counter per dimension
    for (genvar d = 0; d < `HDC_DIM; d++) begin : g_dim

        // bit d of every core, core 0 at lsb
        vote_t vote;

        for (genvar c = 0; c < `HDC_CORE_NUM; c++) begin : g_core
            assign vote[c] = core_vec[c][d];
        end

        // store mask is shared by all dimensions
        dim_counter u_dim_counter (
            .clk      (clk),
            .rst_n    (rst_n),
            .clear    (clear),
            .store    (store),
            .vote     (vote),
            .sign_bit (sign_vec[d])
        );

    end

endmodule

`default_nettype wire

// ==== hw/dim_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hdc_macros.svh"

module dim_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    clear,
    input  hdc_vec_pkg::core_mask_t store,
    input  hdc_vec_pkg::vote_t      vote,
    output logic                    sign_bit
);

    import hdc_vec_pkg::*;

    // per-cycle vote sum spans -CORE_NUM .. +CORE_NUM
    localparam int DELTA_W = $clog2(`HDC_CORE_NUM + 1) + 1;
    // room for count plus delta without overflow
    localparam int SUM_W   = `HDC_CNT_W + DELTA_W;

    // counter range limits
    localparam count_t CNT_MAX = {1'b0, {(`HDC_CNT_W - 1){1'b1}}};
    localparam count_t CNT_MIN = {1'b1, {(`HDC_CNT_W - 1){1'b0}}};

    count_t                    count;
    count_t                    count_nxt;
    logic signed [DELTA_W-1:0] delta;
    logic signed [SUM_W-1:0]   sum;

    // net vote of this cycle
    // enabled one adds, enabled zero subtracts
    always_comb begin
        delta = '0;
        for (int i = 0; i < `HDC_CORE_NUM; i++) begin
            if (store[i]) begin
                if (vote[i]) begin
                    delta = delta + DELTA_W'(1);
                end else begin
                    delta = delta - DELTA_W'(1);
                end
            end
        end
    end

    // wide add, both operands sign extended
    assign sum = count + delta;

    // clip back into counter range
    // sticks at the limits rather than wrapping
    always_comb begin
        if (sum > CNT_MAX) begin
            count_nxt = CNT_MAX;
        end else if (sum < CNT_MIN) begin
            count_nxt = CNT_MIN;
        end else begin
            count_nxt = sum[`HDC_CNT_W-1:0];
        end
    end

    // clear has priority, that cycle's votes are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (|store) begin
            count <= count_nxt;
        end
    end

    // bundled bit, ties and negatives read as 0
    assign sign_bit = (count > 0);

endmodule

`default_nettype wire

// ==== hw/hdc_bundler_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hdc_macros.svh"

module hdc_bundler_top (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // encoder side
    input  logic                                   clear,
    input  hdc_vec_pkg::core_mask_t                store,
    input  hdc_vec_pkg::hv_t [`HDC_CORE_NUM-1:0]   core_vec,
    // readout request
    input  logic                                   read_start,
    output logic                                   busy,
    // readout stream
    output logic                                   out_valid,
    input  logic                                   out_ready,
    output hdc_stream_pkg::word_t                  out_data,
    output logic                                   out_last
);

    import hdc_vec_pkg::*;

    // bundled class vector, sign of each counter
    hv_t sign_vec;

    // vote accumulation, one counter per dimension
    bundle_array u_bundle_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (clear),
        .store    (store),
        .core_vec (core_vec),
        .sign_vec (sign_vec)
    );

    // snapshot and serialize on request
    // first word valid one cycle after read_start
    stream_packer u_stream_packer (
        .clk        (clk),
        .rst_n      (rst_n),
        .sign_vec   (sign_vec),
        .read_start (read_start),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_last   (out_last)
    );

endmodule

`default_nettype wire

// ==== hw/hdc_macros.svh ====
`ifndef HDC_MACROS_SVH
`define HDC_MACROS_SVH

// number of hypervector dimensions
`define HDC_DIM 64

// encoding cores feeding the bundler
`define HDC_CORE_NUM 4

// signed vote counter width per dimension
// 8 bits gives -128 .. 127
`define HDC_CNT_W 8

// readout stream word width
// HDC_DIM must be a whole multiple of this
`define HDC_WORD_W 16

// words in one full readout
`define HDC_WORD_NUM (`HDC_DIM / `HDC_WORD_W)

// word index width, kept at one bit minimum
// so a single-word readout still has a legal index
`define HDC_WORD_IDX_W ((`HDC_WORD_NUM > 1) ? $clog2(`HDC_WORD_NUM) : 1)

`endif

// ==== hw/hdc_stream_pkg.sv ====
`default_nettype none

`include "hdc_macros.svh"

// readout stream side of the bundler
package hdc_stream_pkg;

    // one word on the output stream
    // word k carries dimensions k*WORD_W upward
    typedef logic [`HDC_WORD_W-1:0] word_t;

    // position of a word inside one readout
    // counts 0 .. HDC_WORD_NUM-1
    typedef logic [`HDC_WORD_IDX_W-1:0] word_idx_t;

endpackage

`default_nettype wire

// ==== hw/hdc_vec_pkg.sv ====
`default_nettype none

`include "hdc_macros.svh"

// hypervector side of the bundler
package hdc_vec_pkg;

    // one hypervector, bit d is dimension d
    typedef logic [`HDC_DIM-1:0] hv_t;

    // store enable, one bit per core
    typedef logic [`HDC_CORE_NUM-1:0] core_mask_t;

    // one dimension's bit from each core
    // core 0 in the lsb
    typedef logic [`HDC_CORE_NUM-1:0] vote_t;

    // signed accumulator value of one dimension
    typedef logic signed [`HDC_CNT_W-1:0] count_t;

endpackage

`default_nettype wire

// ==== hw/stream_packer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hdc_macros.svh"

module stream_packer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  hdc_vec_pkg::hv_t      sign_vec,
    input  logic                  read_start,
    output logic                  busy,
    output logic                  out_valid,
    input  logic                  out_ready,
    output hdc_stream_pkg::word_t out_data,
    output logic                  out_last
);

    import hdc_vec_pkg::*;
    import hdc_stream_pkg::*;

    // index of the final word in a readout
    localparam word_idx_t LAST_IDX = word_idx_t'(`HDC_WORD_NUM - 1);

    // frozen copy of the bundled vector
    hv_t       snap;
    // word currently offered on the stream
    word_idx_t idx;
    // request accepted only when idle
    logic      start_acc;
    // handshake on this edge
    logic      xfer;
    logic      at_last;

    assign start_acc = read_start && !busy;
    assign xfer      = out_valid && out_ready;
    assign at_last   = (idx == LAST_IDX);

    // snapshot the sign vector as it stands before this edge
    // later stores leave the readout alone
    always_ff @(posedge clk) begin
        if (start_acc) begin
            snap <= sign_vec;
        end
    end

    // readout control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (xfer) begin
            if (at_last) begin
                // final word gone, back to idle
                busy <= 1'b0;
                idx  <= '0;
            end else begin
                idx  <= idx + word_idx_t'(1);
            end
        end else if (start_acc) begin
            busy <= 1'b1;
            idx  <= '0;
        end
    end

    // a word is on offer for the whole readout
    // held stable under back-pressure since idx only moves on xfer
    assign out_valid = busy;

    // lowest dimensions go first
    assign out_data  = snap[idx * `HDC_WORD_W +: `HDC_WORD_W];

    // last flag only alongside a valid word
    assign out_last  = busy && at_last;

endmodule

`default_nettype wire

// ==== verif/hdc_bundler_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hdc_macros.svh"

module hdc_bundler_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  busy,
    input  logic                  out_valid,
    input  logic                  out_ready,
    input  hdc_stream_pkg::word_t out_data,
    input  logic                  out_last
);

    import hdc_stream_pkg::*;

    // failed assertions so far, read by the testbench
    int assert_fail_cnt = 0;

    // offered word held until it transfers
    a_stall_stable : assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_last)))
        else begin
            $error("stream word changed or dropped while stalled");
            assert_fail_cnt++;
        end

    // last flag only rides on a valid word
    a_last_valid : assert property (@(posedge clk) disable iff (!rst_n)
        out_last |-> out_valid)
        else begin
            $error("out_last high without out_valid");
            assert_fail_cnt++;
        end

    // stream idle right after reset
    a_reset_idle : assert property (@(posedge clk)
        $rose(rst_n) |-> !out_valid)
        else begin
            $error("out_valid high in first cycle after reset");
            assert_fail_cnt++;
        end

    // readout always inside a busy window
    a_valid_busy : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> busy)
        else begin
            $error("out_valid high while busy low");
            assert_fail_cnt++;
        end

endmodule

`default_nettype wire

// ==== verif/hdc_bundler_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "hdc_macros.svh"

module hdc_bundler_tb;

    import hdc_vec_pkg::*;
    import hdc_stream_pkg::*;

    localparam int DIM          = `HDC_DIM;
    localparam int CORE_NUM     = `HDC_CORE_NUM;
    localparam int WORD_W       = `HDC_WORD_W;
    localparam int WORD_NUM     = `HDC_WORD_NUM;
    // counter range of the vote model
    localparam int CNT_HI       = (1 << (`HDC_CNT_W - 1)) - 1;
    localparam int CNT_LO       = -(1 << (`HDC_CNT_W - 1));
    localparam int READ_TIMEOUT = 400;
    localparam int NUM_ROWS     = 26;

    typedef enum {OP_CLEAR, OP_CLR_STORE, OP_STORE, OP_READ} op_e;
    typedef enum {VM_RAND, VM_ONES, VM_ZEROS} vmode_e;
    typedef enum {RDY_ALWAYS, RDY_STALL} rmode_e;

    // mask on a read row drives stores during the readout
    typedef struct {
        op_e        op;
        string      name;
        int         reps;
        core_mask_t mask;
        vmode_e     vmode;
        rmode_e     rmode;
    } row_t;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic                       clear;
    core_mask_t                 store;
    hv_t [`HDC_CORE_NUM-1:0]    core_vec;
    logic                       read_start;
    logic                       busy;
    logic                       out_valid;
    logic                       out_ready;
    word_t                      out_data;
    logic                       out_last;

    // reference vote count per dimension
    int model_cnt [DIM];
    int err_cnt     = 0;
    int timeout_cnt = 0;

    // 31 and 32 drain steps bracket the sign change from the top limit
    row_t rows [NUM_ROWS] = '{
        '{OP_READ,      "reset_zero",       1,   '0,       VM_RAND,  RDY_ALWAYS},
        '{OP_STORE,     "rand_burst_a",     5,   '1,       VM_RAND,  RDY_ALWAYS},
        '{OP_READ,      "rand_read_a",      1,   '0,       VM_RAND,  RDY_ALWAYS},
        '{OP_STORE,     "rand_burst_b",     8,   '1,       VM_RAND,  RDY_ALWAYS},
        '{OP_READ,      "rand_read_b",      1,   '0,       VM_RAND,  RDY_STALL},
        '{OP_STORE,     "partial_mask",     6,   4'b0101,  VM_RAND,  RDY_ALWAYS},
        '{OP_READ,      "partial_read",     1,   '0,       VM_RAND,  RDY_ALWAYS},
        '{OP_STORE,     "zero_mask",        10,  '0,       VM_RAND,  RDY_ALWAYS},
        '{OP_READ,      "zero_mask_read",   1,   '0,       VM_RAND,  RDY_ALWAYS},
        '{OP_CLEAR,     "clear_a",          1,   '0,       VM_ZEROS, RDY_ALWAYS},
        '{OP_READ,      "clear_read",       1,   '0,       VM_RAND,  RDY_ALWAYS},
        '{OP_STORE,     "sat_top",          140, '1,       VM_ONES,  RDY_ALWAYS},
        '{OP_STORE,     "drain_top",        31,  '1,       VM_ZEROS, RDY_ALWAYS},
        '{OP_READ,      "top_held",         1,   '0,       VM_RAND,  RDY_ALWAYS},
        '{OP_STORE,     "drain_top_one",    1,   '1,       VM_ZEROS, RDY_ALWAYS},
        '{OP_READ,      "top_turned",       1,   '0,       VM_RAND,  RDY_ALWAYS},
        '{OP_STORE,     "sat_bottom",       140, '1,       VM_ZEROS, RDY_ALWAYS},
        '{OP_STORE,     "lift_bottom",      32,  '1,       VM_ONES,  RDY_ALWAYS},
        '{OP_READ,      "bottom_tie",       1,   '0,       VM_RAND,  RDY_ALWAYS},
        '{OP_STORE,     "lift_bottom_one",  1,   '1,       VM_ONES,  RDY_ALWAYS},
        '{OP_READ,      "bottom_turned",    1,   '0,       VM_RAND,  RDY_ALWAYS},
        '{OP_STORE,     "stall_prep",       6,   '1,       VM_RAND,  RDY_ALWAYS},
        '{OP_READ,      "stall_busy_votes", 1,   '1,       VM_RAND,  RDY_STALL},
        '{OP_READ,      "after_busy_votes", 1,   '0,       VM_RAND,  RDY_STALL},
        '{OP_CLR_STORE, "clear_with_store", 1,   '1,       VM_ONES,  RDY_ALWAYS},
        '{OP_READ,      "clear_store_read", 1,   '0,       VM_RAND,  RDY_ALWAYS}
    };

    hdc_bundler_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .store      (store),
        .core_vec   (core_vec),
        .read_start (read_start),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_last   (out_last)
    );

    bind hdc_bundler_top hdc_bundler_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .busy      (busy),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

    // 10 ns clock
    always #5 clk = ~clk;

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERROR %s: expected %h, got %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERROR %s: expected %b, got %b", name, exp, act);
            err_cnt++;
        end
    endtask

    function automatic hv_t make_vec(input vmode_e vm);
        hv_t v;
        for (int b = 0; b < DIM; b++) begin
            case (vm)
                VM_ONES:  v[b] = 1'b1;
                VM_ZEROS: v[b] = 1'b0;
                default:  v[b] = 1'($urandom_range(0, 1));
            endcase
        end
        return v;
    endfunction

    // stall roughly one cycle in three
    function automatic logic next_ready(input rmode_e rm);
        if (rm == RDY_STALL) begin
            return ($urandom_range(0, 2) != 0);
        end
        return 1'b1;
    endfunction

    // +1 per enabled one, -1 per enabled zero, then clip
    function automatic void model_apply(input core_mask_t mask, input hv_t [CORE_NUM-1:0] vecs);
        int sum;
        for (int d = 0; d < DIM; d++) begin
            sum = model_cnt[d];
            for (int c = 0; c < CORE_NUM; c++) begin
                if (mask[c]) begin
                    sum += vecs[c][d] ? 1 : -1;
                end
            end
            if (sum > CNT_HI) begin
                sum = CNT_HI;
            end else if (sum < CNT_LO) begin
                sum = CNT_LO;
            end
            model_cnt[d] = sum;
        end
    endfunction

    function automatic void model_clear();
        for (int d = 0; d < DIM; d++) begin
            model_cnt[d] = 0;
        end
    endfunction

    // one cycle of encoder traffic
    // called right after a falling edge
    task automatic drive_votes(input core_mask_t mask, input vmode_e vm, input logic clr);
        hv_t [CORE_NUM-1:0] vecs;
        for (int c = 0; c < CORE_NUM; c++) begin
            vecs[c] = make_vec(vm);
        end
        core_vec = vecs;
        store    = mask;
        clear    = clr;
        // clear beats store in the same cycle
        if (clr) begin
            model_clear();
        end else begin
            model_apply(mask, vecs);
        end
    endtask

    task automatic run_readout(input row_t r);
        word_t exp_words [WORD_NUM];
        hv_t   exp_vec;
        int    got;
        int    cyc;
        logic  v;
        logic  l;
        logic  b;
        word_t d;
        // zero counts read as 0 under the sign rule
        for (int i = 0; i < DIM; i++) begin
            exp_vec[i] = (model_cnt[i] > 0);
        end
        for (int w = 0; w < WORD_NUM; w++) begin
            exp_words[w] = exp_vec[w*WORD_W +: WORD_W];
        end
        @(negedge clk);
        read_start = 1'b1;
        // votes in the request cycle miss the snapshot
        drive_votes(r.mask, VM_RAND, 1'b0);
        out_ready = next_ready(r.rmode);
        got = 0;
        cyc = 0;
        while (got < WORD_NUM && cyc < READ_TIMEOUT) begin
            @(negedge clk);
            cyc++;
            v = out_valid;
            d = out_data;
            l = out_last;
            b = busy;
            // one cycle request latency
            if (cyc == 1) begin
                check_flag($sformatf("%s valid after request", r.name), 1'b1, v);
            end
            // busy holds until the final word has gone
            check_flag($sformatf("%s busy during readout", r.name), 1'b1, b);
            // stray request while busy
            read_start = (cyc == 2);
            drive_votes(r.mask, VM_RAND, 1'b0);
            out_ready = next_ready(r.rmode);
            // transfer happens at the coming rising edge
            if (v && out_ready) begin
                check_word($sformatf("%s word %0d", r.name, got), exp_words[got], d);
                check_flag($sformatf("%s last %0d", r.name, got), (got == WORD_NUM - 1), l);
                got++;
            end
        end
        if (got < WORD_NUM) begin
            $display("timeout in %s: only %0d of %0d words arrived", r.name, got, WORD_NUM);
            timeout_cnt++;
        end
        // busy drops with the final transfer
        // and no second readout follows
        for (int k = 0; k < 2; k++) begin
            @(negedge clk);
            read_start = 1'b0;
            store      = '0;
            out_ready  = 1'b0;
            check_flag($sformatf("%s busy idle %0d", r.name, k), 1'b0, busy);
            check_flag($sformatf("%s valid idle %0d", r.name, k), 1'b0, out_valid);
        end
    endtask

    task automatic run_row(input row_t r);
        case (r.op)
            OP_CLEAR: begin
                @(negedge clk);
                drive_votes('0, VM_ZEROS, 1'b1);
            end
            OP_CLR_STORE: begin
                @(negedge clk);
                drive_votes(r.mask, r.vmode, 1'b1);
            end
            OP_STORE: begin
                for (int i = 0; i < r.reps; i++) begin
                    @(negedge clk);
                    drive_votes(r.mask, r.vmode, 1'b0);
                end
            end
            default: begin
                run_readout(r);
            end
        endcase
    endtask

    initial begin
        int total;
        void'($urandom(32'he797ca4e));
        rst_n      = 1'b0;
        clear      = 1'b0;
        store      = '0;
        core_vec   = '0;
        read_start = 1'b0;
        out_ready  = 1'b0;
        model_clear();
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        @(negedge clk);
        clear = 1'b0;
        store = '0;
        repeat (2) @(negedge clk);
        total = err_cnt + dut.u_checker.assert_fail_cnt + timeout_cnt;
        $display("errors: %0d, assertion failures: %0d, timeouts: %0d",
                 err_cnt, dut.u_checker.assert_fail_cnt, timeout_cnt);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
